// File: hdl/tagPkg.sv
package tagPkg;

    // ------------------------------------------------------------------------
    // tag space
    // ------------------------------------------------------------------------

    // top bit set marks an immediate held in the low bits.
    localparam int tagLen = 7;
    localparam int rfTagLen = tagLen - 1;

    // one physical register per non-immediate tag.
    localparam int numTags = 1 << rfTagLen;

    // group widths.
    localparam int numIssue = 2;
    localparam int numCommit = 2;

    // two sources per lane.
    localparam int numLookup = 2 * numIssue;

    // architectural registers.
    localparam int archLen = 5;
    localparam int numArch = 1 << archLen;

    typedef logic [tagLen-1:0] Tag;
    typedef logic [rfTagLen-1:0] RFTag;
    typedef logic [archLen-1:0] ArchReg;

    // every map entry holds immediate zero out of reset.
    localparam Tag immZeroTag = {1'b1, {(tagLen - 1){1'b0}}};

endpackage

// File: hdl/uopPkg.sv
package uopPkg;

    // ------------------------------------------------------------------------
    // micro-op records
    // ------------------------------------------------------------------------

    // only opAlu takes a physical register.
    // opLoadImm folds its constant into the tag.
    typedef enum logic [1:0] {
        opAlu,
        opLoadImm,
        opStore,
        opBranch
    } Opcode;

    // constant fits below the immediate bit of a tag.
    localparam int immLen = tagPkg::tagLen - 1;

    typedef logic [immLen-1:0] Imm;

    // decoded op entering rename.
    typedef struct packed {
        logic           valid;
        Opcode          op;
        tagPkg::ArchReg dst;
        tagPkg::ArchReg srcA;
        tagPkg::ArchReg srcB;
        Imm             imm;
    } DecodedUop;

    // renamed op leaving the stage.
    typedef struct packed {
        logic       valid;
        Opcode      op;
        tagPkg::Tag dstTag;
        tagPkg::Tag srcATag;
        tagPkg::Tag srcBTag;
    } RenamedUop;

    // retiring op with a destination.
    typedef struct packed {
        logic           valid;
        tagPkg::ArchReg dst;
        tagPkg::Tag     dstTag;
    } CommitEntry;

endpackage

// File: hdl/tagBuffer.sv
`timescale 1ns/1ns

module tagBuffer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mispr,
    input  logic [tagPkg::numIssue-1:0]   issueValid,
    output tagPkg::RFTag                  issueTags [tagPkg::numIssue],
    output logic [tagPkg::numIssue-1:0]   issueTagsValid,
    input  uopPkg::CommitEntry            commit [tagPkg::numCommit],
    input  tagPkg::Tag                    commitPrevTags [tagPkg::numCommit],
    input  logic [tagPkg::numCommit-1:0]  commitNewest
);
    import tagPkg::*;

    // speculative view and view as of the last commit.
    logic [numTags-1:0] freeSpec;
    logic [numTags-1:0] freeCom;

    // extra dead cycle after a restore.
    logic mispredWait;

    RFTag cand [numIssue];
    logic [numIssue-1:0] candValid;
    RFTag pick [numIssue];
    logic [numIssue-1:0] pickValid;
    logic [numIssue-1:0] refill;

    // ------------------------------------------------------------------------
    // priority search
    // ------------------------------------------------------------------------

    // lowest free tag, then lowest of what is left.
    always_comb begin
        logic [numTags-1:0] mask;
        mask = freeSpec;
        for (int k = 0; k < numIssue; k++) begin
            cand[k] = '0;
            candValid[k] = 1'b0;
            for (int t = numTags - 1; t >= 0; t--) begin
                if (mask[t]) begin
                    cand[k] = RFTag'(t);
                    candValid[k] = 1'b1;
                end
            end
            if (candValid[k]) begin
                mask[cand[k]] = 1'b0;
            end
        end
    end

    // empty slots take candidates in lane order.
    always_comb begin
        int rank;
        rank = 0;
        for (int i = 0; i < numIssue; i++) begin
            refill[i] = !issueTagsValid[i] || issueValid[i];
            pick[i] = cand[rank];
            pickValid[i] = candValid[rank] && !mispredWait;
            if (refill[i]) begin
                rank++;
            end
        end
    end

    // ------------------------------------------------------------------------
    // issue slots and free bits
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            freeSpec <= '1;
            freeCom <= '1;
            mispredWait <= 1'b0;
            issueTagsValid <= '0;
        end else begin
            mispredWait <= mispr;

            if (mispr) begin
                // uncommitted tags, held ones included, go back.
                freeSpec <= freeCom;
                issueTagsValid <= '0;
            end else begin
                for (int i = 0; i < numIssue; i++) begin
                    if (refill[i]) begin
                        issueTagsValid[i] <= pickValid[i];
                        if (pickValid[i]) begin
                            issueTags[i] <= pick[i];
                            freeSpec[pick[i]] <= 1'b0;
                        end
                    end
                end
            end

            // overwritten tag returns, new one is pinned.
            // a superseded lane hands its own tag back.
            for (int i = 0; i < numCommit; i++) begin
                if (commit[i].valid) begin
                    if (!commitPrevTags[i][tagLen-1]) begin
                        freeSpec[commitPrevTags[i][rfTagLen-1:0]] <= 1'b1;
                        freeCom[commitPrevTags[i][rfTagLen-1:0]] <= 1'b1;
                    end
                    if (!commit[i].dstTag[tagLen-1]) begin
                        freeSpec[commit[i].dstTag[rfTagLen-1:0]] <= !commitNewest[i];
                        freeCom[commit[i].dstTag[rfTagLen-1:0]] <= !commitNewest[i];
                    end
                end
            end
        end
    end

endmodule

// File: hdl/regAliasTable.sv
`timescale 1ns/1ns

module regAliasTable (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mispr,
    input  tagPkg::ArchReg                lookupRegs [tagPkg::numLookup],
    output tagPkg::Tag                    lookupTags [tagPkg::numLookup],
    input  logic [tagPkg::numIssue-1:0]   writeEn,
    input  tagPkg::ArchReg                writeRegs [tagPkg::numIssue],
    input  tagPkg::Tag                    writeTags [tagPkg::numIssue],
    input  uopPkg::CommitEntry            commit [tagPkg::numCommit],
    output tagPkg::Tag                    commitPrevTags [tagPkg::numCommit],
    output logic [tagPkg::numCommit-1:0]  commitNewest
);
    import tagPkg::*;

    Tag specMap [numArch];
    Tag comMap [numArch];

    // committed map with this cycle's commits applied.
    Tag comNext [numArch];

    // ------------------------------------------------------------------------
    // lookups
    // ------------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < numLookup; i++) begin
            lookupTags[i] = specMap[lookupRegs[i]];
        end
    end

    // ------------------------------------------------------------------------
    // commit side
    // ------------------------------------------------------------------------

    // an older lane in the group to the same register wins the prev tag.
    always_comb begin
        for (int i = 0; i < numCommit; i++) begin
            commitPrevTags[i] = comMap[commit[i].dst];
            commitNewest[i] = 1'b1;
            for (int j = 0; j < i; j++) begin
                if (commit[j].valid && commit[j].dst == commit[i].dst) begin
                    commitPrevTags[i] = commit[j].dstTag;
                end
            end
            for (int j = i + 1; j < numCommit; j++) begin
                if (commit[j].valid && commit[j].dst == commit[i].dst) begin
                    commitNewest[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        comNext = comMap;
        for (int i = 0; i < numCommit; i++) begin
            if (commit[i].valid) begin
                comNext[commit[i].dst] = commit[i].dstTag;
            end
        end
    end

    // ------------------------------------------------------------------------
    // map state
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < numArch; r++) begin
                specMap[r] <= immZeroTag;
                comMap[r] <= immZeroTag;
            end
        end else begin
            comMap <= comNext;
            if (mispr) begin
                // same-cycle writes belong to the squashed path.
                specMap <= comNext;
            end else begin
                for (int i = 0; i < numIssue; i++) begin
                    if (writeEn[i]) begin
                        specMap[writeRegs[i]] <= writeTags[i];
                    end
                end
            end
        end
    end

endmodule

// File: hdl/renameStage.sv
`timescale 1ns/1ns

module renameStage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mispr,
    input  uopPkg::DecodedUop             inUops [tagPkg::numIssue],
    output logic                          stall,
    input  tagPkg::RFTag                  issueTags [tagPkg::numIssue],
    input  logic [tagPkg::numIssue-1:0]   issueTagsValid,
    output logic [tagPkg::numIssue-1:0]   issueValid,
    output tagPkg::ArchReg                lookupRegs [tagPkg::numLookup],
    input  tagPkg::Tag                    lookupTags [tagPkg::numLookup],
    output logic [tagPkg::numIssue-1:0]   writeEn,
    output tagPkg::ArchReg                writeRegs [tagPkg::numIssue],
    output tagPkg::Tag                    writeTags [tagPkg::numIssue],
    output uopPkg::RenamedUop             outUops [tagPkg::numIssue]
);
    import tagPkg::*;
    import uopPkg::*;

    logic [numIssue-1:0] laneValid;
    logic [numIssue-1:0] needTag;
    logic [numIssue-1:0] hasDst;
    logic accept;

    Tag dstTags [numIssue];
    Tag srcATags [numIssue];
    Tag srcBTags [numIssue];

    // any alu lane without a tag holds the whole group.
    assign stall = |(needTag & ~issueTagsValid);
    assign accept = !stall && |laneValid;

    // ------------------------------------------------------------------------
    // per-lane rename
    // ------------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < numIssue; i++) begin
            laneValid[i] = inUops[i].valid;
            needTag[i] = inUops[i].valid && inUops[i].op == opAlu;
            hasDst[i] = inUops[i].valid &&
                        (inUops[i].op == opAlu || inUops[i].op == opLoadImm);

            case (inUops[i].op)
                opAlu:     dstTags[i] = {1'b0, issueTags[i]};
                opLoadImm: dstTags[i] = {1'b1, inUops[i].imm};
                default:   dstTags[i] = immZeroTag;
            endcase

            lookupRegs[2*i] = inUops[i].srcA;
            lookupRegs[2*i+1] = inUops[i].srcB;
            srcATags[i] = lookupTags[2*i];
            srcBTags[i] = lookupTags[2*i+1];

            // older lanes in the group are not in the map yet.
            for (int j = 0; j < i; j++) begin
                if (hasDst[j] && inUops[j].dst == inUops[i].srcA) begin
                    srcATags[i] = dstTags[j];
                end
                if (hasDst[j] && inUops[j].dst == inUops[i].srcB) begin
                    srcBTags[i] = dstTags[j];
                end
            end

            issueValid[i] = accept && needTag[i];
            writeEn[i] = accept && hasDst[i];
            writeRegs[i] = inUops[i].dst;
            writeTags[i] = dstTags[i];
        end
    end

    // ------------------------------------------------------------------------
    // output register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        for (int i = 0; i < numIssue; i++) begin
            outUops[i].op <= inUops[i].op;
            outUops[i].dstTag <= dstTags[i];
            outUops[i].srcATag <= srcATags[i];
            outUops[i].srcBTag <= srcBTags[i];
            if (rst) begin
                outUops[i].valid <= 1'b0;
            end else begin
                outUops[i].valid <= accept && laneValid[i] && !mispr;
            end
        end
    end

endmodule

// File: hdl/renameTop.sv
`timescale 1ns/1ns

module renameTop (
    input  logic                 clk,
    input  logic                 rst,
    input  uopPkg::DecodedUop    inUops [tagPkg::numIssue],
    input  uopPkg::CommitEntry   commit [tagPkg::numCommit],
    input  logic                 mispr,
    output uopPkg::RenamedUop    outUops [tagPkg::numIssue],
    output logic                 stall
);
    import tagPkg::*;

    RFTag issueTags [numIssue];
    logic [numIssue-1:0] issueTagsValid;
    logic [numIssue-1:0] issueValid;

    ArchReg lookupRegs [numLookup];
    Tag lookupTags [numLookup];
    logic [numIssue-1:0] writeEn;
    ArchReg writeRegs [numIssue];
    Tag writeTags [numIssue];

    Tag commitPrevTags [numCommit];
    logic [numCommit-1:0] commitNewest;

    tagBuffer tagBuf (
        .clk(clk),
        .rst(rst),
        .mispr(mispr),
        .issueValid(issueValid),
        .issueTags(issueTags),
        .issueTagsValid(issueTagsValid),
        .commit(commit),
        .commitPrevTags(commitPrevTags),
        .commitNewest(commitNewest)
    );

    regAliasTable rat (
        .clk(clk),
        .rst(rst),
        .mispr(mispr),
        .lookupRegs(lookupRegs),
        .lookupTags(lookupTags),
        .writeEn(writeEn),
        .writeRegs(writeRegs),
        .writeTags(writeTags),
        .commit(commit),
        .commitPrevTags(commitPrevTags),
        .commitNewest(commitNewest)
    );

    renameStage stage (
        .clk(clk),
        .rst(rst),
        .mispr(mispr),
        .inUops(inUops),
        .stall(stall),
        .issueTags(issueTags),
        .issueTagsValid(issueTagsValid),
        .issueValid(issueValid),
        .lookupRegs(lookupRegs),
        .lookupTags(lookupTags),
        .writeEn(writeEn),
        .writeRegs(writeRegs),
        .writeTags(writeTags),
        .outUops(outUops)
    );

endmodule

// File: verif/tbClock.sv
`timescale 1ns/1ns

module tbClock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for ten rising edges.
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: verif/tagBufferChecker.sv
`timescale 1ns/1ns

module tagBufferChecker (
    input logic                        clk,
    input logic                        rst,
    input logic                        mispr,
    input logic [tagPkg::numIssue-1:0] issueValid,
    input logic [tagPkg::numIssue-1:0] issueTagsValid
);
    // a lane consumes only a tag it holds.
    issueHasTag: assert property (@(posedge clk) disable iff (rst)
        (issueValid & ~issueTagsValid) == '0)
        else $error("issueValid on a lane without a valid tag");

    // slots start empty.
    resetEmpty: assert property (@(posedge clk) $past(rst) |-> issueTagsValid == '0)
        else $error("issue tag valid in the cycle after reset");

    // two dead cycles after a restore.
    misprFirst: assert property (@(posedge clk) disable iff (rst)
        $past(mispr) |-> issueTagsValid == '0)
        else $error("issue tag valid one cycle after mispredict");

    misprSecond: assert property (@(posedge clk) disable iff (rst)
        $past(mispr, 2) |-> issueTagsValid == '0)
        else $error("issue tag valid two cycles after mispredict");

endmodule

bind tagBuffer tagBufferChecker chk (.*);

// File: verif/renameTb.sv
`timescale 1ns/1ns

module renameTb;
    import tagPkg::*;
    import uopPkg::*;

    localparam int maxRows = 64;

    logic clk;
    logic rst;
    DecodedUop inUops [numIssue];
    CommitEntry commit [numCommit];
    logic mispr;
    RenamedUop outUops [numIssue];
    logic stall;

    // producer ids in the stimulus table are row*2+lane.
    DecodedUop rowU [maxRows][2];
    int rowC [maxRows][2];
    bit rowMis [maxRows];
    int rowExp [maxRows][4];
    int rowHold [maxRows];
    int rowDstFrom [maxRows];
    int numRows = 0;

    // reference model state.
    int buildSpec [numArch];
    int buildCom [numArch];
    ArchReg prodDst [2*maxRows];
    Tag obsTag [2*maxRows];
    Tag comRt [numArch];
    bit [numTags-1:0] live;

    int valueErrors = 0;
    int otherErrors = 0;
    int cycles = 0;
    int cycleLimit = 1000;

    tbClock clkGen (.clk(clk), .rst(rst));

    renameTop uut (
        .clk(clk),
        .rst(rst),
        .inUops(inUops),
        .commit(commit),
        .mispr(mispr),
        .outUops(outUops),
        .stall(stall)
    );

    function automatic DecodedUop mkUop(logic v, Opcode op, ArchReg d, ArchReg a, ArchReg b,
                                        Imm imm);
        DecodedUop u;
        u.valid = v;
        u.op = op;
        u.dst = d;
        u.srcA = a;
        u.srcB = b;
        u.imm = imm;
        return u;
    endfunction

    function automatic bit writesDst(DecodedUop u);
        return u.valid && (u.op == opAlu || u.op == opLoadImm);
    endfunction

    task automatic checkVal(string name, int got, int exp);
        if (got != exp) begin
            valueErrors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // table building with the expected source producers
    // ------------------------------------------------------------------------

    task automatic addRow(DecodedUop u0, DecodedUop u1, int c0, int c1, bit mis, int hold,
                          int dstFrom);
        DecodedUop u [2];
        int r;
        u[0] = u0;
        u[1] = u1;
        r = numRows;
        for (int i = 0; i < 2; i++) begin
            rowU[r][i] = u[i];
            rowExp[r][2*i] = buildSpec[u[i].srcA];
            rowExp[r][2*i+1] = buildSpec[u[i].srcB];
        end
        // lane 0 feeds lane 1 inside the group.
        if (writesDst(u[0]) && u[0].dst == u[1].srcA) rowExp[r][2] = 2 * r;
        if (writesDst(u[0]) && u[0].dst == u[1].srcB) rowExp[r][3] = 2 * r;
        for (int i = 0; i < 2; i++) begin
            prodDst[2*r+i] = u[i].dst;
            if (writesDst(u[i]) && !mis) buildSpec[u[i].dst] = 2 * r + i;
        end
        rowC[r][0] = c0;
        rowC[r][1] = c1;
        if (c0 >= 0) buildCom[prodDst[c0]] = c0;
        if (c1 >= 0) buildCom[prodDst[c1]] = c1;
        if (mis) buildSpec = buildCom;
        rowMis[r] = mis;
        rowHold[r] = hold;
        rowDstFrom[r] = dstFrom;
        numRows++;
    endtask

    task automatic buildTable();
        DecodedUop none;
        none = mkUop(1'b0, opAlu, 5'd0, 5'd0, 5'd0, 6'd0);
        addRow(mkUop(1'b1, opLoadImm, 5'd1, 5'd0, 5'd0, 6'd5),
               mkUop(1'b1, opAlu, 5'd2, 5'd1, 5'd0, 6'd0), -1, -1, 0, -1, -1);
        addRow(mkUop(1'b1, opAlu, 5'd3, 5'd2, 5'd1, 6'd0),
               mkUop(1'b1, opLoadImm, 5'd4, 5'd3, 5'd2, 6'd3), -1, -1, 0, -1, -1);
        addRow(mkUop(1'b1, opStore, 5'd0, 5'd4, 5'd1, 6'd0),
               mkUop(1'b1, opBranch, 5'd0, 5'd3, 5'd0, 6'd0), -1, -1, 0, -1, -1);
        // fill the free list.
        for (int k = 0; k < 31; k++) begin
            addRow(mkUop(1'b1, opAlu, 5'd10, 5'd10, 5'd11, 6'd0),
                   mkUop(1'b1, opAlu, 5'd11, 5'd10, 5'd11, 6'd0), -1, -1, 0, -1, -1);
        end
        addRow(none, none, 0, 1, 0, -1, -1);
        addRow(none, none, 2, 3, 0, -1, -1);
        addRow(none, none, 6, 7, 0, -1, -1);
        // full list until overwriting r10 releases a tag.
        addRow(mkUop(1'b1, opAlu, 5'd12, 5'd10, 5'd11, 6'd0), none, 8, -1, 0, 2, 6);
        addRow(mkUop(1'b1, opAlu, 5'd13, 5'd12, 5'd10, 6'd0),
               mkUop(1'b1, opAlu, 5'd14, 5'd13, 5'd11, 6'd0), 9, 10, 0, -1, -1);
        addRow(mkUop(1'b1, opAlu, 5'd15, 5'd14, 5'd13, 6'd0),
               mkUop(1'b1, opAlu, 5'd16, 5'd15, 5'd10, 6'd0), 11, 12, 0, -1, -1);
        // loads beside the mispredict are squashed.
        addRow(mkUop(1'b1, opLoadImm, 5'd10, 5'd10, 5'd11, 6'd9),
               mkUop(1'b1, opLoadImm, 5'd11, 5'd10, 5'd0, 6'd7), 13, 14, 1, -1, -1);
        addRow(mkUop(1'b1, opAlu, 5'd20, 5'd10, 5'd11, 6'd0),
               mkUop(1'b1, opAlu, 5'd21, 5'd12, 5'd13, 6'd0), -1, -1, 0, 2, -1);
        for (int k = 0; k < 16; k++) begin
            addRow(mkUop(1'($urandom % 4 != 0), Opcode'($urandom % 4), ArchReg'($urandom % 8),
                         ArchReg'($urandom % 8), ArchReg'($urandom % 8), Imm'($urandom)),
                   mkUop(1'($urandom % 4 != 0), Opcode'($urandom % 4), ArchReg'($urandom % 8),
                         ArchReg'($urandom % 8), ArchReg'($urandom % 8), Imm'($urandom)),
                   -1, -1, 0, -1, -1);
        end
    endtask

    // ------------------------------------------------------------------------
    // driving and checking
    // ------------------------------------------------------------------------

    task automatic driveRow(int r);
        Tag prev;
        int id;
        for (int i = 0; i < 2; i++) begin
            inUops[i] = rowU[r][i];
            commit[i] = '0;
            id = rowC[r][i];
            if (id >= 0) begin
                commit[i].valid = 1'b1;
                commit[i].dst = prodDst[id];
                commit[i].dstTag = obsTag[id];
                prev = comRt[prodDst[id]];
                if (!prev[tagLen-1]) live[prev[rfTagLen-1:0]] = 1'b0;
                comRt[prodDst[id]] = obsTag[id];
            end
        end
        mispr = rowMis[r];
        if (rowMis[r]) begin
            live = '0;
            for (int a = 0; a < numArch; a++) begin
                if (!comRt[a][tagLen-1]) live[comRt[a][rfTagLen-1:0]] = 1'b1;
            end
        end
    endtask

    task automatic checkOutputs(int r);
        Tag t;
        Tag exp;
        int id;
        for (int i = 0; i < 2; i++) begin
            id = 2 * r + i;
            checkVal("outUops.valid", int'(outUops[i].valid),
                     int'(rowU[r][i].valid && !rowMis[r]));
            if (outUops[i].valid) begin
                checkVal("outUops.op", int'(outUops[i].op), int'(rowU[r][i].op));
                for (int s = 0; s < 2; s++) begin
                    exp = (rowExp[r][2*i+s] < 0) ? immZeroTag : obsTag[rowExp[r][2*i+s]];
                    t = (s == 0) ? outUops[i].srcATag : outUops[i].srcBTag;
                    checkVal(s == 0 ? "outUops.srcATag" : "outUops.srcBTag", int'(t), int'(exp));
                end
                t = outUops[i].dstTag;
                obsTag[id] = t;
                if (rowU[r][i].op == opLoadImm) begin
                    checkVal("outUops.dstTag", int'(t), int'({1'b1, rowU[r][i].imm}));
                end else if (rowU[r][i].op == opAlu) begin
                    if (t[tagLen-1]) begin
                        otherErrors++;
                        $display("row %0d lane %0d: alu destination got an immediate tag", r, i);
                    end else if (live[t[rfTagLen-1:0]]) begin
                        otherErrors++;
                        $display("row %0d lane %0d: tag %h issued while still live", r, i, t);
                    end
                    live[t[rfTagLen-1:0]] = 1'b1;
                    if (i == 0 && rowDstFrom[r] >= 0) begin
                        checkVal("outUops.dstTag", int'(t), int'(obsTag[rowDstFrom[r]]));
                    end
                end
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("timeout: no result after %0d cycles", cycleLimit);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int hold;
        bit waiting;
        void'($urandom(32'hbb54));
        for (int i = 0; i < 2; i++) begin
            inUops[i] = '0;
            commit[i] = '0;
        end
        mispr = 1'b0;
        live = '0;
        for (int a = 0; a < numArch; a++) begin
            buildSpec[a] = -1;
            buildCom[a] = -1;
            comRt[a] = immZeroTag;
        end
        buildTable();
        cycleLimit = 4 * numRows + 200;

        while (rst !== 1'b0) @(posedge clk);
        @(posedge clk);
        #1;
        for (int r = 0; r < numRows; r++) begin
            driveRow(r);
            hold = 0;
            waiting = 1'b1;
            while (waiting) begin
                @(negedge clk);
                if (stall && (rowU[r][0].valid || rowU[r][1].valid)) begin
                    hold++;
                    @(posedge clk);
                    #1;
                    commit[0] = '0;
                    commit[1] = '0;
                    mispr = 1'b0;
                    // a stalled group leaves nothing on the output.
                    for (int i = 0; i < 2; i++) begin
                        checkVal("outUops.valid", int'(outUops[i].valid), 0);
                    end
                end else begin
                    waiting = 1'b0;
                end
            end
            if (rowHold[r] >= 0) checkVal("stall cycles", hold, rowHold[r]);
            @(posedge clk);
            #1;
            inUops[0] = '0;
            inUops[1] = '0;
            commit[0] = '0;
            commit[1] = '0;
            mispr = 1'b0;
            checkOutputs(r);
        end

        $display("errors: %0d value mismatches, %0d other", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: renameTop.f
hdl/tagPkg.sv
hdl/uopPkg.sv
hdl/tagBuffer.sv
hdl/regAliasTable.sv
hdl/renameStage.sv
hdl/renameTop.sv
verif/tbClock.sv
verif/tagBufferChecker.sv
verif/renameTb.sv

// File: run.sh
#!/bin/sh
# Build and run the rename stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module renameTb -f renameTop.f -o renameSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/renameSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
